// File: include/tilemap_settings.svh
`ifndef TILEMAP_SETTINGS_SVH
`define TILEMAP_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// geometry
//////////////////////////////////////////////////////////////////////

// log2 of cell width, 8 pixel cells
`define TM_CELL_BITS 3

// tile RAM depth in bytes
`define TM_RAM_WORDS 8192

//////////////////////////////////////////////////////////////////////
// scroll register offsets on cpuAddr[1:0]
//////////////////////////////////////////////////////////////////////

// hscroll low byte
`define TM_REG_HLO 2'd0
// hscroll bit 8, priority, page, flip
`define TM_REG_HHI 2'd1
// vscroll
`define TM_REG_V 2'd2

`endif

// File: verilog/tilemapPkg.sv
package tilemapPkg;

	//////////////////////////////////////////////////////////////////////
	// screen position types
	//////////////////////////////////////////////////////////////////////

	// 9-bit horizontal pixel position
	typedef logic [8:0] hPos_t;
	// 8-bit vertical line position
	typedef logic [7:0] vPos_t;

	//////////////////////////////////////////////////////////////////////
	// tile data and address types
	//////////////////////////////////////////////////////////////////////

	// second byte bits 1..0 above first byte
	typedef logic [9:0] tileCode_t;
	// page, cell row (5), cell column (6), byte select
	typedef logic [12:0] ramAddr_t;
	// tile code (10), fine row (3), nibble select
	typedef logic [13:0] gfxAddr_t;
	// layer priority for the mixer
	typedef logic [2:0] prio_t;

	// pack a tile RAM address from its fields
	function automatic ramAddr_t makeRamAddr(input logic pg, input logic [4:0] cellRow,
		input logic [5:0] cellCol, input logic byteSel);
		return {pg, cellRow, cellCol, byteSel};
	endfunction

	// pack a pattern ROM address from its fields
	function automatic gfxAddr_t makeGfxAddr(input tileCode_t code, input logic [2:0] fineRow,
		input logic nibbleSel);
		return {code, fineRow, nibbleSel};
	endfunction

endpackage

// File: verilog/videoCounters.sv
`timescale 1ns/1ns

module videoCounters (
	input logic CLK_6M,
	input logic arstN,
	input logic hsync,
	input logic vsync,
	output tilemapPkg::hPos_t hCount,
	output tilemapPkg::vPos_t vCount
);

	// previous sync samples
	logic hsyncLast;
	logic vsyncLast;

	// rising edge strobes
	logic hsyncRise;
	logic vsyncRise;

	//////////////////////////////////////////////////////////////////////
	// sync edge detection
	//////////////////////////////////////////////////////////////////////

	// high now and low last cycle
	assign hsyncRise = hsync & ~hsyncLast;
	assign vsyncRise = vsync & ~vsyncLast;

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			hsyncLast <= 1'b0;
			vsyncLast <= 1'b0;
		end else begin
			hsyncLast <= hsync;
			vsyncLast <= vsync;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// pixel and line counters
	//////////////////////////////////////////////////////////////////////

	// horizontal counter
	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			hCount <= '0;
		end else if (hsyncRise) begin
			// new line starts at pixel 0
			hCount <= '0;
		end else begin
			// free running, wraps at 512
			hCount <= hCount + 1'b1;
		end
	end

	// vertical counter
	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			vCount <= '0;
		end else if (vsyncRise) begin
			// vsync wins over a coincident hsync
			vCount <= '0;
		end else if (hsyncRise) begin
			vCount <= vCount + 1'b1;
		end
	end

endmodule

// File: verilog/scrollRegs.sv
`timescale 1ns/1ns

`include "tilemap_settings.svh"

module scrollRegs (
	input logic CLK_6M,
	input logic arstN,
	input logic latch,
	input logic [1:0] regSel,
	input logic [7:0] regData,
	output tilemapPkg::hPos_t hScroll,
	output tilemapPkg::vPos_t vScroll,
	output logic page,
	output logic flip,
	output tilemapPkg::prio_t layerPrio
);

	//////////////////////////////////////////////////////////////////////
	// CPU latched registers
	//////////////////////////////////////////////////////////////////////

	// fields hold between latch strobes
	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			hScroll <= '0;
			vScroll <= '0;
			page <= 1'b0;
			flip <= 1'b0;
			layerPrio <= '0;
		end else if (latch) begin
			case (regSel)
				`TM_REG_HLO: begin
					// low byte of hscroll only
					hScroll[7:0] <= regData;
				end
				`TM_REG_HHI: begin
					// ninth hscroll bit
					hScroll[8] <= regData[0];
					// priority passes straight to the mixer
					layerPrio <= regData[3:1];
					// selects upper half of tile RAM
					page <= regData[4];
					// screen flip
					flip <= regData[5];
				end
				`TM_REG_V: begin
					vScroll <= regData;
				end
				default: begin
					// offset 3 has no register
				end
			endcase
		end
	end

endmodule

// File: verilog/tileRam.sv
`timescale 1ns/1ns

`include "tilemap_settings.svh"

module tileRam (
	input logic CLK_6M,
	input logic ramSel,
	input logic cpuWe,
	input tilemapPkg::ramAddr_t cpuAddr,
	input logic [7:0] cpuWrData,
	input tilemapPkg::ramAddr_t vidAddr,
	output logic [7:0] cpuRdData,
	output logic [7:0] vidData
);
	import tilemapPkg::*;

	// tile bytes, two per cell
	logic [7:0] mem [`TM_RAM_WORDS];

	// shared address after the port mux
	ramAddr_t ramAddr;

	// CPU read in progress
	logic cpuRead;

	//////////////////////////////////////////////////////////////////////
	// address mux
	//////////////////////////////////////////////////////////////////////

	// CPU owns the RAM while selected
	assign ramAddr = ramSel ? cpuAddr : vidAddr;
	assign cpuRead = ramSel & ~cpuWe;

	//////////////////////////////////////////////////////////////////////
	// memory array
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (ramSel && cpuWe) begin
			mem[ramAddr] <= cpuWrData;
		end
	end

	// video port sees whatever address is on the RAM
	// so a CPU access corrupts the video byte
	always_ff @(posedge CLK_6M) begin
		vidData <= mem[ramAddr];
	end

	// CPU data bus idles low between reads
	always_ff @(posedge CLK_6M) begin
		if (cpuRead) begin
			cpuRdData <= mem[ramAddr];
		end else begin
			cpuRdData <= 8'h00;
		end
	end

endmodule

// File: verilog/tileFetch.sv
`timescale 1ns/1ns

`include "tilemap_settings.svh"

module tileFetch (
	input logic CLK_6M,
	input logic arstN,
	input tilemapPkg::hPos_t hCount,
	input tilemapPkg::vPos_t vCount,
	input tilemapPkg::hPos_t hScroll,
	input tilemapPkg::vPos_t vScroll,
	input logic page,
	input logic flip,
	input logic [7:0] vidData,
	output tilemapPkg::ramAddr_t vidAddr,
	output tilemapPkg::gfxAddr_t gfxAddr,
	output logic nibbleA,
	output logic nibbleB
);
	import tilemapPkg::*;

	// counters after optional flip
	hPos_t hBase;
	vPos_t vBase;

	// scrolled position
	hPos_t sh;
	vPos_t sv;

	// pixel within the cell
	logic [`TM_CELL_BITS-1:0] phase;

	// fine row within the cell
	logic [`TM_CELL_BITS-1:0] fineRow;

	// second request of the cell
	logic byteSel;

	// first byte of the cell
	logic [7:0] byte0;

	// code held for the second nibble
	tileCode_t code;

	// code as it is being captured
	tileCode_t newCode;

	//////////////////////////////////////////////////////////////////////
	// scrolled position
	//////////////////////////////////////////////////////////////////////

	// flip inverts the raw counters
	assign hBase = flip ? ~hCount : hCount;
	assign vBase = flip ? ~vCount : vCount;

	assign sh = hBase + hScroll;
	assign sv = vBase + vScroll;

	assign phase = sh[`TM_CELL_BITS-1:0];
	assign fineRow = sv[`TM_CELL_BITS-1:0];

	//////////////////////////////////////////////////////////////////////
	// tile RAM requests
	//////////////////////////////////////////////////////////////////////

	// phase 0 asks for byte 0, phase 2 for byte 1
	assign byteSel = (phase == 3'd2);

	assign vidAddr = makeRamAddr(page, sv[7:`TM_CELL_BITS], sh[8:`TM_CELL_BITS], byteSel);

	//////////////////////////////////////////////////////////////////////
	// byte capture
	//////////////////////////////////////////////////////////////////////

	// byte 1 bits 1..0 join byte 0 on the fly
	assign newCode = {vidData[1:0], byte0};

	// read data lands one cycle after each request
	always_ff @(posedge CLK_6M) begin
		if (phase == 3'd1) begin
			byte0 <= vidData;
		end
		if (phase == 3'd3) begin
			// kept so the next cell can start fetching
			code <= newCode;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// pattern address and nibble strobes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M or negedge arstN) begin
		if (!arstN) begin
			nibbleA <= 1'b0;
			nibbleB <= 1'b0;
			gfxAddr <= '0;
		end else begin
			// one cycle strobes
			nibbleA <= (phase == 3'd3);
			nibbleB <= (phase == 3'd7);
			if (phase == 3'd3) begin
				// first nibble
				gfxAddr <= makeGfxAddr(newCode, fineRow, 1'b0);
			end else if (phase == 3'd7) begin
				// second nibble from the held code
				gfxAddr <= makeGfxAddr(code, fineRow, 1'b1);
			end
		end
	end

endmodule

// File: verilog/tilemapTop.sv
`timescale 1ns/1ns

module tilemapTop (
	input logic CLK_6M,
	input logic arstN,
	input logic hsync,
	input logic vsync,
	input logic [13:0] cpuAddr,
	input logic [7:0] cpuWrData,
	output logic [7:0] cpuRdData,
	input logic cpuWe,
	input logic ramSel,
	input logic latch,
	output tilemapPkg::gfxAddr_t gfxAddr,
	output logic nibbleA,
	output logic nibbleB,
	output tilemapPkg::prio_t layerPrio
);
	import tilemapPkg::*;

	// screen position
	hPos_t hCount;
	vPos_t vCount;

	// register fields
	hPos_t hScroll;
	vPos_t vScroll;
	logic page;
	logic flip;

	// video RAM port
	ramAddr_t vidAddr;
	logic [7:0] vidData;

	//////////////////////////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////////////////////////

	videoCounters uCounters (
		.CLK_6M(CLK_6M),
		.arstN(arstN),
		.hsync(hsync),
		.vsync(vsync),
		.hCount(hCount),
		.vCount(vCount)
	);

	// register offset on the two low address bits
	scrollRegs uRegs (
		.CLK_6M(CLK_6M),
		.arstN(arstN),
		.latch(latch),
		.regSel(cpuAddr[1:0]),
		.regData(cpuWrData),
		.hScroll(hScroll),
		.vScroll(vScroll),
		.page(page),
		.flip(flip),
		.layerPrio(layerPrio)
	);

	tileRam uRam (
		.CLK_6M(CLK_6M),
		.ramSel(ramSel),
		.cpuWe(cpuWe),
		.cpuAddr(cpuAddr[12:0]),
		.cpuWrData(cpuWrData),
		.vidAddr(vidAddr),
		.cpuRdData(cpuRdData),
		.vidData(vidData)
	);

	tileFetch uFetch (
		.CLK_6M(CLK_6M),
		.arstN(arstN),
		.hCount(hCount),
		.vCount(vCount),
		.hScroll(hScroll),
		.vScroll(vScroll),
		.page(page),
		.flip(flip),
		.vidData(vidData),
		.vidAddr(vidAddr),
		.gfxAddr(gfxAddr),
		.nibbleA(nibbleA),
		.nibbleB(nibbleB)
	);

endmodule

// File: tb/tilemapTb_props.sv
`timescale 1ns/1ns

module tilemapTb_props (
	input logic CLK_6M,
	input logic arstN,
	input tilemapPkg::hPos_t sh,
	input logic nibbleA,
	input logic nibbleB
);

	//////////////////////////////////////////////////////////////////////
	// nibble strobe rules
	//////////////////////////////////////////////////////////////////////

	// the two nibbles of a cell never share a cycle
	neverTogether: assert property (@(posedge CLK_6M) disable iff (!arstN)
		!(nibbleA && nibbleB))
		else $error("nibbleA and nibbleB were high in the same cycle");

	// single cycle pulse while the scrolled position moves one pixel
	// a sync restart or a scroll write may land on phase 3 or 7 again
	singleA: assert property (@(posedge CLK_6M) disable iff (!arstN)
		(nibbleA && (sh - $past(sh) == 9'd1 || $past(sh) - sh == 9'd1))
		|=> !nibbleA)
		else $error("nibbleA stayed high for more than one cycle");

	singleB: assert property (@(posedge CLK_6M) disable iff (!arstN)
		(nibbleB && (sh - $past(sh) == 9'd1 || $past(sh) - sh == 9'd1))
		|=> !nibbleB)
		else $error("nibbleB stayed high for more than one cycle");

	// reset holds both strobes low
	quietInReset: assert property (@(posedge CLK_6M) !arstN |-> (!nibbleA && !nibbleB))
		else $error("a nibble strobe was high during reset");

endmodule

// File: tb/tilemapTb.sv
`timescale 1ns/1ns

`include "tilemap_settings.svh"

module tilemapTb;
	import tilemapPkg::*;

	// run lengths in cycles
	localparam int RAM_OPS = 300;
	localparam int REG_OPS = 200;
	localparam int VID_RUN = 4000;
	localparam int ROUNDS = 3;
	localparam int LIMIT = 2 * RAM_OPS + REG_OPS + `TM_RAM_WORDS
		+ (ROUNDS + 1) * (VID_RUN + 3) + 2000;

	// DUT inputs
	logic CLK_6M = 1'b0;
	logic arstN = 1'b0;
	logic hsync = 1'b0;
	logic vsync = 1'b0;
	logic [13:0] cpuAddr = '0;
	logic [7:0] cpuWrData = '0;
	logic cpuWe = 1'b0;
	logic ramSel = 1'b0;
	logic latch = 1'b0;

	// DUT outputs
	logic [7:0] cpuRdData;
	gfxAddr_t gfxAddr;
	logic nibbleA;
	logic nibbleB;
	prio_t layerPrio;

	// reference model state as it stands after the last edge
	logic [7:0] mirror [`TM_RAM_WORDS];
	logic mHsLast, mVsLast, mPage, mFlip;
	hPos_t mH, mHScroll;
	vPos_t mV, mVScroll;
	prio_t mPrio;
	logic [7:0] mVid, mRd, mByte0;
	tileCode_t mCode;

	// expected strobes with the cycle each one is due
	int dueQ[$];
	gfxAddr_t gfxQ[$];
	logic kindQ[$];
	logic [12:0] addrQ[$];

	int seed = 53238;
	int cycle = 0;
	int wdCycles = 0;
	int errors = 0;
	int checks = 0;
	logic checkGfx = 1'b0;
	string testName = "reset";
	logic [31:0] rnd;

	tilemapTop u_dut (.*);

	bind tileFetch tilemapTb_props uProps (.CLK_6M(CLK_6M), .arstN(arstN), .sh(sh),
		.nibbleA(nibbleA), .nibbleB(nibbleB));

	always #5 CLK_6M = ~CLK_6M;

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// advance the model over the coming edge with the inputs now driven
	task automatic predictEdge();
		hPos_t sh;
		vPos_t sv;
		logic [12:0] addr;
		logic hsRise;
		logic vsRise;
		sh = (mFlip ? ~mH : mH) + mHScroll;
		sv = (mFlip ? ~mV : mV) + mVScroll;
		// page over cell row and column over byte 1 on phase 2
		addr = ramSel ? cpuAddr[12:0] : {mPage, sv[7:3], sh[8:3], sh[2:0] == 3'd2};
		// nibbleA after phase 3 and nibbleB after phase 7
		if (sh[2:0] == 3'd3) begin
			dueQ.push_back(cycle + 1);
			gfxQ.push_back({mVid[1:0], mByte0, sv[2:0], 1'b0});
			kindQ.push_back(1'b0);
			mCode = {mVid[1:0], mByte0};
		end
		if (sh[2:0] == 3'd7) begin
			dueQ.push_back(cycle + 1);
			gfxQ.push_back({mCode, sv[2:0], 1'b1});
			kindQ.push_back(1'b1);
		end
		if (sh[2:0] == 3'd1) begin
			mByte0 = mVid;
		end
		// both read ports see the old byte on a write
		mRd = (ramSel && !cpuWe) ? mirror[addr] : 8'h00;
		mVid = mirror[addr];
		if (ramSel && cpuWe) begin
			mirror[addr] = cpuWrData;
		end
		if (latch) begin
			case (cpuAddr[1:0])
				`TM_REG_HLO: mHScroll[7:0] = cpuWrData;
				`TM_REG_HHI: begin
					mHScroll[8] = cpuWrData[0];
					mPrio = cpuWrData[3:1];
					mPage = cpuWrData[4];
					mFlip = cpuWrData[5];
				end
				`TM_REG_V: mVScroll = cpuWrData;
				default: ;
			endcase
		end
		hsRise = hsync && !mHsLast;
		vsRise = vsync && !mVsLast;
		mHsLast = hsync;
		mVsLast = vsync;
		mH = hsRise ? 9'd0 : mH + 9'd1;
		if (vsRise) begin
			mV = 8'd0;
		end else if (hsRise) begin
			mV = mV + 8'd1;
		end
	endtask

	task automatic compareValue(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s %s: expected %0h actual %0h", testName, what, exp, act);
		end
	endtask

	// one clock then every output against the model
	task automatic stepCycle();
		logic expA;
		logic expB;
		predictEdge();
		@(posedge CLK_6M);
		#1;
		cycle++;
		expA = 1'b0;
		expB = 1'b0;
		if (dueQ.size() > 0 && dueQ[0] == cycle) begin
			expA = !kindQ[0];
			expB = kindQ[0];
			if (checkGfx) begin
				compareValue("gfxAddr", 32'(gfxQ[0]), 32'(gfxAddr));
			end
			void'(dueQ.pop_front());
			void'(gfxQ.pop_front());
			void'(kindQ.pop_front());
		end
		compareValue("nibbleA", 32'(expA), 32'(nibbleA));
		compareValue("nibbleB", 32'(expB), 32'(nibbleB));
		compareValue("cpuRdData", 32'(mRd), 32'(cpuRdData));
		compareValue("layerPrio", 32'(mPrio), 32'(layerPrio));
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic writeReg(input logic [1:0] sel, input logic [7:0] data);
		cpuAddr = {12'd0, sel};
		cpuWrData = data;
		latch = 1'b1;
		stepCycle();
		latch = 1'b0;
	endtask

	// sync pulses with random line lengths and 40 lines a frame
	task automatic runVideo(input int n);
		int lineLen;
		int pos;
		int line;
		lineLen = 64;
		pos = 0;
		line = 0;
		for (int i = 0; i < n; i++) begin
			hsync = (pos < 4);
			vsync = (line == 0);
			// codes are known once a full cell has been read
			checkGfx = (i >= 20);
			stepCycle();
			pos++;
			if (pos == lineLen) begin
				pos = 0;
				line = (line + 1) % 40;
				rnd = $random(seed);
				lineLen = 56 + int'(rnd[4:0]);
			end
		end
		checkGfx = 1'b0;
		hsync = 1'b0;
		vsync = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		{mHsLast, mVsLast, mPage, mFlip, mH, mV, mHScroll, mVScroll, mPrio} = '0;
		mRd = 8'h00;
		repeat (2) @(posedge CLK_6M);
		// video address is 0 while held in reset
		mVid = mirror[0];
		#1;
		arstN = 1'b1;
		compareValue("nibbleA", 32'd0, 32'(nibbleA));
		compareValue("nibbleB", 32'd0, 32'(nibbleB));
		compareValue("cpuRdData", 32'd0, 32'(cpuRdData));

		testName = "ramAccess";
		ramSel = 1'b1;
		cpuWe = 1'b1;
		repeat (RAM_OPS) begin
			rnd = $random(seed);
			cpuAddr = rnd[13:0];
			cpuWrData = rnd[21:14];
			addrQ.push_back(rnd[12:0]);
			stepCycle();
		end
		// read back with each result on the next edge
		cpuWe = 1'b0;
		while (addrQ.size() > 0) begin
			cpuAddr = {1'b0, addrQ.pop_front()};
			stepCycle();
		end
		ramSel = 1'b0;

		testName = "registers";
		repeat (REG_OPS) begin
			rnd = $random(seed);
			cpuAddr = {12'd0, rnd[1:0]};
			cpuWrData = rnd[9:2];
			latch = rnd[10];
			stepCycle();
		end
		latch = 1'b0;

		testName = "unscrolledFetch";
		ramSel = 1'b1;
		cpuWe = 1'b1;
		for (int a = 0; a < `TM_RAM_WORDS; a++) begin
			rnd = $random(seed);
			cpuAddr = 14'(a);
			cpuWrData = rnd[7:0];
			stepCycle();
		end
		ramSel = 1'b0;
		cpuWe = 1'b0;
		writeReg(`TM_REG_HLO, 8'h00);
		writeReg(`TM_REG_HHI, 8'h00);
		writeReg(`TM_REG_V, 8'h00);
		runVideo(VID_RUN);

		// page 1 in every round and flip from the second round on
		testName = "scrollPageFlip";
		for (int r = 0; r < ROUNDS; r++) begin
			rnd = $random(seed);
			writeReg(`TM_REG_HLO, rnd[7:0]);
			writeReg(`TM_REG_HHI, {2'b00, r != 0, 1'b1, rnd[11:8]});
			writeReg(`TM_REG_V, rnd[19:12]);
			runVideo(VID_RUN);
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog on the total run length
	always @(posedge CLK_6M) begin
		wdCycles++;
		if (wdCycles > LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

// File: list.f
+incdir+include
verilog/tilemapPkg.sv
verilog/videoCounters.sv
verilog/scrollRegs.sv
verilog/tileRam.sv
verilog/tileFetch.sv
verilog/tilemapTop.sv
tb/tilemapTb_props.sv
tb/tilemapTb.sv

// File: run.sh
#!/bin/sh
# build and run the tilemap testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tilemapTb -f list.f -o tilemapSim

# pass or fail comes from the log
./obj_dir/tilemapSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
	exit 0
fi
exit 1
